//--- Bender.yml
package:
  name: cpu_pipe

sources:
  - files:
      - verilog/cpuPkg.sv
      - verilog/pipeIf.sv
      - verilog/fetchUnit.sv
      - verilog/decodeUnit.sv
      - verilog/regFile.sv
      - verilog/executeUnit.sv
      - verilog/memoryUnit.sv
      - verilog/cpuTop.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/cpuTb.sv

//--- verification/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// architectural state of the reference machine
logic [31:0] modelRegs [32];
logic [31:0] modelMem [64];
logic [4:0] expReg [$];
logic [31:0] expData [$];
int modelledCount = 0;

function automatic logic [31:0] encR(input logic [5:0] funct, input logic [4:0] rs,
	input logic [4:0] rt, input logic [4:0] rd);
	return {6'b000000, rs, rt, rd, 5'b00000, funct};
endfunction

function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
	input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] encJ(input logic [25:0] index);
	return {cpuPkg::opJ, index};
endfunction

// $0 stays zero and is never reported
function automatic void modelWrite(input logic [4:0] dest, input logic [31:0] value);
	if (dest != 5'd0) begin
		modelRegs[dest] = value;
		expReg.push_back(dest);
		expData.push_back(value);
	end
endfunction

// one instruction at a time, no delay slot
task automatic runModel(input int len);
	logic [31:0] pc, ins, a, b, imm, addr;
	for (int i = 0; i < 32; i++)
		modelRegs[i] = '0;
	for (int i = 0; i < 64; i++)
		modelMem[i] = '0;
	expReg.delete();
	expData.delete();
	pc = '0;
	while (pc < len * 4) begin
		ins = progMem[pc >> 2];
		a = modelRegs[ins[25:21]];
		b = modelRegs[ins[20:16]];
		imm = {{16{ins[15]}}, ins[15:0]};
		addr = a + imm;
		pc = pc + 32'd4;
		case (ins[31:26])
			cpuPkg::opRtype: begin
				case (ins[5:0])
					cpuPkg::fnAdd: modelWrite(ins[15:11], a + b);
					cpuPkg::fnSub: modelWrite(ins[15:11], a - b);
					cpuPkg::fnAnd: modelWrite(ins[15:11], a & b);
					cpuPkg::fnOr: modelWrite(ins[15:11], a | b);
					cpuPkg::fnSlt: modelWrite(ins[15:11], {31'd0, $signed(a) < $signed(b)});
					default: ;
				endcase
			end
			cpuPkg::opAddi: modelWrite(ins[20:16], addr);
			cpuPkg::opLw: modelWrite(ins[20:16], modelMem[addr[7:2]]);
			cpuPkg::opSw: modelMem[addr[7:2]] = b;
			cpuPkg::opBeq: if (a == b) pc = pc + {imm[29:0], 2'b00};
			cpuPkg::opJ: pc = {pc[31:28], ins[25:0], 2'b00};
			default: ;
		endcase
		modelledCount++;
	end
endtask

`endif

//--- verification/cpuTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTb;

	localparam int clkPeriod = 40;
	localparam int resetCycles = 16;
	localparam int drainCycles = 16;
	localparam int numTests = 5;
	localparam int totalInstr = 8 + 40 + 60 + 60 + 200;
	// eight cycles per instruction, plus reset and drain for each test
	localparam int budgetCycles = 8 * (totalInstr + numTests)
		+ numTests * (resetCycles + drainCycles + 8);

	logic clk;
	logic reset;
	logic [31:0] instrAddr;
	logic [31:0] instr;
	logic wbValid;
	logic [4:0] wbReg;
	logic [31:0] wbData;

	logic [31:0] progMem [512];
	int progLen = 0;
	logic [31:0] rngState;

	`include "isaModel.svh"

	cpuTop i_dut (.clk, .reset, .instrAddr, .instr, .wbValid, .wbReg, .wbData);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// past the end of the program every word is a j to itself
	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		if ((addr >> 2) < progLen)
			return progMem[addr >> 2];
		return encJ(addr[27:2]);
	endfunction

	always @(negedge clk)
		instr = fetchWord(instrAddr);

	function automatic logic [31:0] nextRand();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	function automatic int randRange(input int n);
		return int'(nextRand() % n);
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic emit(input logic [31:0] word);
		progMem[progLen] = word;
		progLen++;
	endtask

	////////////////////////////////////////////////////////////
	// program generation
	////////////////////////////////////////////////////////////
	// mode 0 addi, 1 ALU chain, 2 memory, 3 control, 4 everything
	task automatic genProgram(input int len, input int mode);
		int kind;
		logic [4:0] ra, rb, rc;
		logic [15:0] imm;
		cpuPkg::functT fn [5];
		fn = '{cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd, cpuPkg::fnOr, cpuPkg::fnSlt};
		progLen = 0;
		while (progLen < len) begin
			case (mode)
				0: kind = 0;
				1: kind = randRange(2);
				2: kind = (randRange(3) + 1) % 3 == 0 ? 0 : randRange(2) + 2;
				3: kind = randRange(4) >= 2 ? randRange(2) + 4 : randRange(2);
				default: kind = randRange(6);
			endcase
			ra = 5'(1 + randRange(7));
			rb = 5'(1 + randRange(7));
			rc = 5'(1 + randRange(7));
			if (mode <= 1 || randRange(2) == 0)
				imm = 16'(-1 - randRange(1000));
			else
				imm = 16'(nextRand());
			case (kind)
				0: emit(encI(cpuPkg::opAddi, rb, ra, imm));
				1: emit(encR(fn[randRange(5)], rb, rc, ra));
				2: emit(encI(cpuPkg::opSw, 5'd0, ra, 16'(randRange(64) * 4)));
				3: begin
					emit(encI(cpuPkg::opLw, 5'd0, ra, 16'(randRange(64) * 4)));
					// load-use right behind the load
					if (randRange(2) == 0)
						emit(encR(cpuPkg::fnAdd, ra, rb, rc));
				end
				4: begin
					emit(encI(cpuPkg::opAddi, rb, ra, 16'(randRange(2))));
					emit(encI(cpuPkg::opBeq, ra, rb, 16'(randRange(4))));
				end
				default: emit(encJ(26'(progLen + 1 + randRange(4))));
			endcase
		end
	endtask

	task automatic applyReset();
		@(negedge clk);
		reset = 1'b0;
		repeat (resetCycles) begin
			@(negedge clk);
			checkValue("wbValid", wbValid, 32'd0);
			checkValue("instrAddr", instrAddr, 32'd0);
		end
		reset = 1'b1;
		// first write-back needs four edges
		repeat (3) begin
			@(negedge clk);
			checkValue("wbValid", wbValid, 32'd0);
		end
	endtask

	task automatic runTest(input int len, input int mode, input string name);
		int got;
		genProgram(len, mode);
		runModel(progLen);
		applyReset();
		got = 0;
		while (got < expReg.size()) begin
			@(negedge clk);
			if (wbValid) begin
				checkValue("wbReg", wbReg, expReg[got]);
				checkValue("wbData", wbData, expData[got]);
				got++;
			end
		end
		// nothing squashed or extra may follow
		repeat (drainCycles) begin
			@(negedge clk);
			checkValue("wbValid", wbValid, 32'd0);
		end
		$display("%s: %0d instructions, %0d write-backs", name, progLen, got);
	endtask

	initial begin
		#(budgetCycles * clkPeriod);
		$display("watchdog expired, write-backs stopped arriving from the pipeline");
		$display("SOME TESTS FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		reset = 1'b0;
		instr = '0;
		rngState = 32'hf6fd_63a1;
		runTest(8, 0, "reset and addi");
		runTest(40, 1, "ALU chain");
		runTest(60, 2, "loads and stores");
		runTest(60, 3, "branches and jumps");
		runTest(200, 4, "mixed program");
		$display("modelled %0d instructions", modelledCount);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

	////////////////////////////////////////////////////////////
	// widths and sizes
	////////////////////////////////////////////////////////////
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount = 32;
	localparam int dataMemWords = 64;
	localparam int dataMemAddrWidth = 6;

	// instruction field positions, fixed by the ISA
	localparam int opLsb = 26;
	localparam int rsLsb = 21;
	localparam int rtLsb = 16;
	localparam int rdLsb = 11;
	localparam int immWidth = 16;
	localparam int jumpIdxWidth = 26;
	localparam int functWidth = 6;

	////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////
	typedef enum logic [5:0] {
		opRtype = 6'b000000,
		opJ     = 6'b000010,
		opBeq   = 6'b000100,
		opAddi  = 6'b001000,
		opLw    = 6'b100011,
		opSw    = 6'b101011
	} opcodeT;

	typedef enum logic [5:0] {
		fnAdd = 6'b100000,
		fnSub = 6'b100010,
		fnAnd = 6'b100100,
		fnOr  = 6'b100101,
		fnSlt = 6'b101010
	} functT;

	// same codes as the classic ALU control table
	typedef enum logic [3:0] {
		aluAnd = 4'b0000,
		aluOr  = 4'b0001,
		aluAdd = 4'b0010,
		aluSub = 4'b0110,
		aluSlt = 4'b0111
	} aluOpT;

endpackage

`default_nettype wire

//--- verilog/cpuTop.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTop (
	input logic clk,
	input logic reset,
	output logic [cpuPkg::dataWidth-1:0] instrAddr,
	input logic [cpuPkg::dataWidth-1:0] instr,
	output logic wbValid,
	output logic [cpuPkg::regAddrWidth-1:0] wbReg,
	output logic [cpuPkg::dataWidth-1:0] wbData
);

	redirectIf redirect ();
	forwardIf fwd ();

	// IF/ID
	logic [cpuPkg::dataWidth-1:0] idInstr, idPcPlus4;
	logic [cpuPkg::regAddrWidth-1:0] rsAddr, rtAddr;
	logic [cpuPkg::dataWidth-1:0] rsData, rtData;

	// ID/EX
	logic exRegWrite, exMemToReg, exMemRead, exMemWrite, exBranch, exAluSrc;
	cpuPkg::functT exFunct;
	cpuPkg::opcodeT exOpcode;
	logic [cpuPkg::regAddrWidth-1:0] exRs, exRt, exRd;
	logic [cpuPkg::dataWidth-1:0] exRsData, exRtData, exImm, exPcPlus4;

	// EX/MEM
	logic memMemRead, memMemWrite, memMemToReg, memRegWriteIn;
	logic [cpuPkg::regAddrWidth-1:0] memRdIn;
	logic [cpuPkg::dataWidth-1:0] memStoreData, memResultIn;

	fetchUnit i_fetch (.clk, .reset, .redirect(redirect.fetch), .instrAddr, .instr,
		.idInstr, .idPcPlus4);

	decodeUnit i_decode (.clk, .reset, .idInstr, .idPcPlus4, .redirect(redirect.decode),
		.rsAddr, .rtAddr, .rsData, .rtData, .exRegWrite, .exMemToReg, .exMemRead,
		.exMemWrite, .exBranch, .exAluSrc, .exFunct, .exOpcode, .exRs, .exRt, .exRd,
		.exRsData, .exRtData, .exImm, .exPcPlus4);

	regFile i_regFile (.clk, .reset, .rsAddr, .rtAddr, .rsData, .rtData, .fwd(fwd.regfile));

	executeUnit i_execute (.clk, .reset, .exRegWrite, .exMemToReg, .exMemRead, .exMemWrite,
		.exBranch, .exAluSrc, .exFunct, .exOpcode, .exRs, .exRt, .exRd, .exRsData, .exRtData,
		.exImm, .exPcPlus4, .redirect(redirect.execute), .fwd(fwd.execute), .memMemRead,
		.memMemWrite, .memMemToReg, .memStoreData, .memRegWriteIn, .memRdIn, .memResultIn);

	memoryUnit i_memory (.clk, .reset, .memMemRead, .memMemWrite, .memMemToReg,
		.memStoreData, .memRegWriteIn, .memRdIn, .memResultIn, .fwd(fwd.memory));

	// every register write-back is visible outside
	assign wbValid = fwd.wbRegWrite;
	assign wbReg = fwd.wbRd;
	assign wbData = fwd.wbData;

endmodule

`default_nettype wire

//--- verilog/decodeUnit.sv
`timescale 1ns/10ps
`default_nettype none

module decodeUnit (
	input logic clk,
	input logic reset,
	input logic [cpuPkg::dataWidth-1:0] idInstr,
	input logic [cpuPkg::dataWidth-1:0] idPcPlus4,
	redirectIf.decode redirect,
	output logic [cpuPkg::regAddrWidth-1:0] rsAddr,
	output logic [cpuPkg::regAddrWidth-1:0] rtAddr,
	input logic [cpuPkg::dataWidth-1:0] rsData,
	input logic [cpuPkg::dataWidth-1:0] rtData,
	output logic exRegWrite,
	output logic exMemToReg,
	output logic exMemRead,
	output logic exMemWrite,
	output logic exBranch,
	output logic exAluSrc,
	output cpuPkg::functT exFunct,
	output cpuPkg::opcodeT exOpcode,
	output logic [cpuPkg::regAddrWidth-1:0] exRs,
	output logic [cpuPkg::regAddrWidth-1:0] exRt,
	output logic [cpuPkg::regAddrWidth-1:0] exRd,
	output logic [cpuPkg::dataWidth-1:0] exRsData,
	output logic [cpuPkg::dataWidth-1:0] exRtData,
	output logic [cpuPkg::dataWidth-1:0] exImm,
	output logic [cpuPkg::dataWidth-1:0] exPcPlus4
);

	cpuPkg::opcodeT opcode;
	logic [cpuPkg::regAddrWidth-1:0] rdAddr;
	logic [cpuPkg::regAddrWidth-1:0] dest;
	logic [cpuPkg::dataWidth-1:0] imm;
	logic regWrite, memToReg, memRead, memWrite, branch, aluSrc, regDst;

	assign opcode = cpuPkg::opcodeT'(idInstr[cpuPkg::dataWidth-1:cpuPkg::opLsb]);
	assign rsAddr = idInstr[cpuPkg::rsLsb +: cpuPkg::regAddrWidth];
	assign rtAddr = idInstr[cpuPkg::rtLsb +: cpuPkg::regAddrWidth];
	assign rdAddr = idInstr[cpuPkg::rdLsb +: cpuPkg::regAddrWidth];

	////////////////////////////////////////////////////////////
	// control decode
	////////////////////////////////////////////////////////////
	always_comb begin
		regWrite = 1'b0;
		memToReg = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branch = 1'b0;
		aluSrc = 1'b0;
		regDst = 1'b0;
		case (opcode)
			cpuPkg::opRtype: begin
				regWrite = 1'b1;
				regDst = 1'b1;
			end
			cpuPkg::opAddi: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
			end
			cpuPkg::opLw: begin
				regWrite = 1'b1;
				memToReg = 1'b1;
				memRead = 1'b1;
				aluSrc = 1'b1;
			end
			cpuPkg::opSw: begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
			end
			cpuPkg::opBeq: branch = 1'b1;
			default: ;
		endcase
	end

	assign dest = regDst ? rdAddr : rtAddr;
	assign imm = {{(cpuPkg::dataWidth - cpuPkg::immWidth){idInstr[cpuPkg::immWidth-1]}},
		idInstr[cpuPkg::immWidth-1:0]};

	// j resolves here, one fetched slot is lost
	assign redirect.jump = (opcode == cpuPkg::opJ);
	assign redirect.jumpTarget = {idPcPlus4[31:28], idInstr[cpuPkg::jumpIdxWidth-1:0], 2'b00};

	// load-use hazard, j has no source registers
	assign redirect.stall = exMemRead && (opcode != cpuPkg::opJ)
		&& ((exRt == rsAddr) || (exRt == rtAddr));

	////////////////////////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			exRegWrite <= 1'b0;
			exMemToReg <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exBranch <= 1'b0;
		end else if (redirect.stall || redirect.branchTaken) begin
			exRegWrite <= 1'b0;
			exMemToReg <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exBranch <= 1'b0;
		end else begin
			// $0 is never a real destination
			exRegWrite <= regWrite && (dest != '0);
			exMemToReg <= memToReg;
			exMemRead <= memRead;
			exMemWrite <= memWrite;
			exBranch <= branch;
		end
	end

	always_ff @(posedge clk) begin
		exAluSrc <= aluSrc;
		exFunct <= cpuPkg::functT'(idInstr[cpuPkg::functWidth-1:0]);
		exOpcode <= opcode;
		exRs <= rsAddr;
		exRt <= rtAddr;
		exRd <= dest;
		exRsData <= rsData;
		exRtData <= rtData;
		exImm <= imm;
		exPcPlus4 <= idPcPlus4;
	end

endmodule

`default_nettype wire

//--- verilog/executeUnit.sv
`timescale 1ns/10ps
`default_nettype none

module executeUnit (
	input logic clk,
	input logic reset,
	input logic exRegWrite,
	input logic exMemToReg,
	input logic exMemRead,
	input logic exMemWrite,
	input logic exBranch,
	input logic exAluSrc,
	input cpuPkg::functT exFunct,
	input cpuPkg::opcodeT exOpcode,
	input logic [cpuPkg::regAddrWidth-1:0] exRs,
	input logic [cpuPkg::regAddrWidth-1:0] exRt,
	input logic [cpuPkg::regAddrWidth-1:0] exRd,
	input logic [cpuPkg::dataWidth-1:0] exRsData,
	input logic [cpuPkg::dataWidth-1:0] exRtData,
	input logic [cpuPkg::dataWidth-1:0] exImm,
	input logic [cpuPkg::dataWidth-1:0] exPcPlus4,
	redirectIf.execute redirect,
	forwardIf.execute fwd,
	output logic memMemRead,
	output logic memMemWrite,
	output logic memMemToReg,
	output logic [cpuPkg::dataWidth-1:0] memStoreData,
	output logic memRegWriteIn,
	output logic [cpuPkg::regAddrWidth-1:0] memRdIn,
	output logic [cpuPkg::dataWidth-1:0] memResultIn
);

	cpuPkg::aluOpT aluOp;
	logic [cpuPkg::dataWidth-1:0] opA, fwdB, opB;
	logic [cpuPkg::dataWidth-1:0] aluResult;
	logic aluZero;

	// ALU control
	always_comb begin
		aluOp = cpuPkg::aluAdd;
		case (exOpcode)
			cpuPkg::opRtype: begin
				case (exFunct)
					cpuPkg::fnSub: aluOp = cpuPkg::aluSub;
					cpuPkg::fnAnd: aluOp = cpuPkg::aluAnd;
					cpuPkg::fnOr: aluOp = cpuPkg::aluOr;
					cpuPkg::fnSlt: aluOp = cpuPkg::aluSlt;
					default: aluOp = cpuPkg::aluAdd;
				endcase
			end
			cpuPkg::opBeq: aluOp = cpuPkg::aluSub;
			default: aluOp = cpuPkg::aluAdd;
		endcase
	end

	////////////////////////////////////////////////////////////
	// operand forwarding, the younger MEM result wins
	////////////////////////////////////////////////////////////
	always_comb begin
		if (fwd.memRegWrite && (fwd.memRd == exRs))
			opA = fwd.memResult;
		else if (fwd.wbRegWrite && (fwd.wbRd == exRs))
			opA = fwd.wbData;
		else
			opA = exRsData;

		if (fwd.memRegWrite && (fwd.memRd == exRt))
			fwdB = fwd.memResult;
		else if (fwd.wbRegWrite && (fwd.wbRd == exRt))
			fwdB = fwd.wbData;
		else
			fwdB = exRtData;
	end

	assign opB = exAluSrc ? exImm : fwdB;

	always_comb begin
		case (aluOp)
			cpuPkg::aluAnd: aluResult = opA & opB;
			cpuPkg::aluOr: aluResult = opA | opB;
			cpuPkg::aluAdd: aluResult = opA + opB;
			cpuPkg::aluSub: aluResult = opA - opB;
			cpuPkg::aluSlt: aluResult = {31'd0, $signed(opA) < $signed(opB)};
			default: aluResult = opA;
		endcase
	end

	// beq decided here on forwarded operands
	assign aluZero = (aluResult == '0);
	assign redirect.branchTaken = exBranch && aluZero;
	assign redirect.branchTarget = exPcPlus4 + {exImm[cpuPkg::dataWidth-3:0], 2'b00};

	////////////////////////////////////////////////////////////
	// EX/MEM register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			memRegWriteIn <= 1'b0;
			memMemRead <= 1'b0;
			memMemWrite <= 1'b0;
			memMemToReg <= 1'b0;
		end else begin
			memRegWriteIn <= exRegWrite;
			memMemRead <= exMemRead;
			memMemWrite <= exMemWrite;
			memMemToReg <= exMemToReg;
		end
	end

	always_ff @(posedge clk) begin
		memRdIn <= exRd;
		memResultIn <= aluResult;
		memStoreData <= fwdB;
	end

	// slot behind a taken beq is a bubble from decode
	noStoreAfterTaken: assert property (@(posedge clk) disable iff (!reset)
		redirect.branchTaken |=> !exMemWrite)
		else $error("squashed instruction reached EX with a store");

endmodule

`default_nettype wire

//--- verilog/fetchUnit.sv
`timescale 1ns/10ps
`default_nettype none

module fetchUnit (
	input logic clk,
	input logic reset,
	redirectIf.fetch redirect,
	output logic [cpuPkg::dataWidth-1:0] instrAddr,
	input logic [cpuPkg::dataWidth-1:0] instr,
	output logic [cpuPkg::dataWidth-1:0] idInstr,
	output logic [cpuPkg::dataWidth-1:0] idPcPlus4
);

	logic [cpuPkg::dataWidth-1:0] pc;
	logic [cpuPkg::dataWidth-1:0] pcPlus4;
	logic [cpuPkg::dataWidth-1:0] nextPc;

	assign pcPlus4 = pc + 32'd4;
	assign instrAddr = pc;

	// a taken branch overrides everything, even a stall
	always_comb begin
		if (redirect.branchTaken)
			nextPc = redirect.branchTarget;
		else if (redirect.jump)
			nextPc = redirect.jumpTarget;
		else if (redirect.stall)
			nextPc = pc;
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc <= '0;
			idInstr <= '0;
		end else begin
			pc <= nextPc;
			// flushed slot becomes sll $0,$0,0
			if (redirect.branchTaken || redirect.jump)
				idInstr <= '0;
			else if (!redirect.stall)
				idInstr <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (!redirect.stall)
			idPcPlus4 <= pcPlus4;
	end

	// targets come from decode and execute
	pcAligned: assert property (@(posedge clk) disable iff (!reset) pc[1:0] == 2'b00)
		else $error("fetch address not word aligned");

endmodule

`default_nettype wire

//--- verilog/memoryUnit.sv
`timescale 1ns/10ps
`default_nettype none

module memoryUnit (
	input logic clk,
	input logic reset,
	input logic memMemRead,
	input logic memMemWrite,
	input logic memMemToReg,
	input logic [cpuPkg::dataWidth-1:0] memStoreData,
	input logic memRegWriteIn,
	input logic [cpuPkg::regAddrWidth-1:0] memRdIn,
	input logic [cpuPkg::dataWidth-1:0] memResultIn,
	forwardIf.memory fwd
);

	logic [cpuPkg::dataWidth-1:0] dataMem [cpuPkg::dataMemWords];
	logic [cpuPkg::dataMemAddrWidth-1:0] wordIdx;
	logic [cpuPkg::dataWidth-1:0] loadData;

	// word index from byte address
	assign wordIdx = memResultIn[cpuPkg::dataMemAddrWidth+1:2];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < cpuPkg::dataMemWords; i++)
				dataMem[i] <= '0;
		end else if (memMemWrite) begin
			dataMem[wordIdx] <= memStoreData;
		end
	end

	assign loadData = memMemRead ? dataMem[wordIdx] : '0;

	// MEM group for bypassing into EX
	assign fwd.memRegWrite = memRegWriteIn;
	assign fwd.memRd = memRdIn;
	assign fwd.memResult = memResultIn;

	// MEM/WB register, write-back data already selected
	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			fwd.wbRegWrite <= 1'b0;
		else
			fwd.wbRegWrite <= memRegWriteIn;
	end

	always_ff @(posedge clk) begin
		fwd.wbRd <= memRdIn;
		fwd.wbData <= memMemToReg ? loadData : memResultIn;
	end

	readWriteExclusive: assert property (@(posedge clk) disable iff (!reset)
		!(memMemRead && memMemWrite))
		else $error("data memory read and write in the same cycle");

endmodule

`default_nettype wire

//--- verilog/pipeIf.sv
`timescale 1ns/10ps
`default_nettype none

// control transfers and stall, seen by the fetch stage
interface redirectIf;
	logic jump;
	logic [cpuPkg::dataWidth-1:0] jumpTarget;
	logic stall;
	logic branchTaken;
	logic [cpuPkg::dataWidth-1:0] branchTarget;

	modport fetch (input jump, jumpTarget, stall, branchTaken, branchTarget);
	modport decode (output jump, jumpTarget, stall, input branchTaken);
	modport execute (output branchTaken, branchTarget);
endinterface

// MEM and WB stage results for bypassing
interface forwardIf;
	logic memRegWrite;
	logic [cpuPkg::regAddrWidth-1:0] memRd;
	logic [cpuPkg::dataWidth-1:0] memResult;
	logic wbRegWrite;
	logic [cpuPkg::regAddrWidth-1:0] wbRd;
	logic [cpuPkg::dataWidth-1:0] wbData;

	modport memory (output memRegWrite, memRd, memResult, wbRegWrite, wbRd, wbData);
	modport execute (input memRegWrite, memRd, memResult, wbRegWrite, wbRd, wbData);
	modport regfile (input wbRegWrite, wbRd, wbData);
endinterface

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input logic clk,
	input logic reset,
	input logic [cpuPkg::regAddrWidth-1:0] rsAddr,
	input logic [cpuPkg::regAddrWidth-1:0] rtAddr,
	output logic [cpuPkg::dataWidth-1:0] rsData,
	output logic [cpuPkg::dataWidth-1:0] rtData,
	forwardIf.regfile fwd
);

	logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < cpuPkg::regCount; i++)
				regs[i] <= '0;
		end else if (fwd.wbRegWrite) begin
			regs[fwd.wbRd] <= fwd.wbData;
		end
	end

	// write-through, so ID sees the value WB writes this cycle
	assign rsData = (fwd.wbRegWrite && (fwd.wbRd == rsAddr)) ? fwd.wbData : regs[rsAddr];
	assign rtData = (fwd.wbRegWrite && (fwd.wbRd == rtAddr)) ? fwd.wbData : regs[rtAddr];

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verification
verilog/cpuPkg.sv
verilog/pipeIf.sv
verilog/fetchUnit.sv
verilog/decodeUnit.sv
verilog/regFile.sv
verilog/executeUnit.sv
verilog/memoryUnit.sv
verilog/cpuTop.sv
verification/cpuTb.sv
